// ==== cpu.f ====
logic/cpu_pkg.sv
logic/program_memory.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/cpu.sv
verification/cpu_properties.sv
verification/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - logic/cpu_pkg.sv
  - logic/program_memory.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/hazard_unit.sv
  - logic/execute_stage.sv
  - logic/mem_stage.sv
  - logic/cpu.sv
  - target: test
    files:
      - verification/cpu_properties.sv
      - verification/cpu_tb.sv

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

   typedef word_t [31:0] reg_file_t;            // Index 0 is x0

   localparam int    HALT_TIMEOUT    = 2000;    // Cycles
   localparam int    RANDOM_PROGRAMS = 20;
   localparam int    BODY_LEN        = 24;      // Random instructions per program
   localparam int    WINDOW_WORDS    = 8;       // Data words touched by random LW/SW
   localparam word_t EBREAK_INSTR    = 32'h0010_0073;

   logic       clk        = 1'b0;
   logic       arst_n     = 1'b0;
   word_t      prog_addr  = '0;
   logic [7:0] prog_data  = '0;
   logic       prog_we    = 1'b0;
   logic       run        = 1'b0;
   reg_idx_t   debug_addr = '0;
   word_t      debug_data;
   logic       halted;

   word_t  image [256];                         // Program being built, word per slot
   int     image_len   = 0;
   int     error_count = 0;
   integer seed        = 90647;

   cpu dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .prog_addr  (prog_addr),
      .prog_data  (prog_data),
      .prog_we    (prog_we),
      .run        (run),
      .debug_addr (debug_addr),
      .debug_data (debug_data),
      .halted     (halted)
   );

   initial begin
      forever #5 clk = ~clk;                    // 10 ns period
   end

   // Bound checker failures end the run at once
   always @(dut.u_cpu_properties.failures) begin
      if (dut.u_cpu_properties.failures != 0) begin
         error_count++;
         $display("assertion failure at %0t ns: a bound property of the DUT was violated",
                  $time);
         $display("Done: errors found");
         $fatal(1, "bound assertion failed");
      end
   end

   // RV32I instruction formats
   function automatic word_t r_type(int funct7, int rs2, int rs1, int funct3, int rd);
      return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], OPC_OP};
   endfunction

   function automatic word_t i_type(int imm, int rs1, int funct3, int rd, logic [6:0] opc);
      return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opc};
   endfunction

   function automatic word_t s_type(int imm, int rs2, int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
   endfunction

   function automatic word_t b_type(int imm, int rs2, int rs1, int funct3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
              OPC_BRANCH};
   endfunction

   function automatic word_t u_type(int imm, int rd);
      return {imm[19:0], rd[4:0], OPC_LUI};
   endfunction

   function automatic word_t j_type(int imm, int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
   endfunction

   function automatic word_t addi(int rd, int rs1, int imm);
      return i_type(imm, rs1, 0, rd, OPC_OPIMM);
   endfunction

   function automatic void emit(word_t instr);
      image[image_len] = instr;
      image_len++;
   endfunction

   function automatic int rand_below(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // ISA interpreter over its own state, stops at EBREAK
   function automatic reg_file_t iss_run();
      reg_file_t  regs;
      word_t      dmem [DMEM_WORDS];
      word_t      pc;
      word_t      ins;
      word_t      a;
      word_t      b;
      word_t      result;
      word_t      imm_i;
      word_t      imm_s;
      word_t      imm_b;
      word_t      imm_j;
      logic [6:0] opc;
      logic [4:0] rd;
      int         steps;
      logic       done;
      regs = '0;
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = '0;
      end
      pc    = '0;
      steps = 0;
      done  = 1'b0;
      while (!done && steps < 4096) begin
         if (pc[31:2] >= image_len) begin
            done = 1'b1;                        // Ran off the image
         end else begin
            ins   = image[pc[9:2]];
            opc   = ins[6:0];
            rd    = ins[11:7];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            pc    = pc + 32'd4;
            case (opc)
               OPC_OP, OPC_OPIMM: begin
                  if (opc == OPC_OPIMM) begin
                     b = imm_i;
                  end
                  case (ins[14:12])
                     3'b000:  result = (opc == OPC_OP && ins[30]) ? a - b : a + b;
                     3'b111:  result = a & b;
                     3'b110:  result = a | b;
                     3'b100:  result = a ^ b;
                     3'b010:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                     default: result = '0;
                  endcase
                  regs[rd] = result;
               end
               OPC_LUI:    regs[rd] = {ins[31:12], 12'b0};
               OPC_LOAD:   regs[rd] = dmem[((a + imm_i) >> 2) % DMEM_WORDS];
               OPC_STORE:  dmem[((a + imm_s) >> 2) % DMEM_WORDS] = b;
               OPC_BRANCH: begin
                  if ((a == b) != ins[12]) begin   // funct3 bit 0 picks BNE
                     pc = pc - 32'd4 + imm_b;
                  end
               end
               OPC_JAL: begin
                  regs[rd] = pc;                   // Link is pc+4
                  pc       = pc - 32'd4 + imm_j;
               end
               OPC_SYSTEM: done = 1'b1;
               default: ;
            endcase
            regs[0] = '0;
            steps++;
         end
      end
      return regs;
   endfunction

   task automatic check_word(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         error_count++;
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("Done: errors found");
         $fatal(1, "register value check failed");
      end
   endtask

   task automatic check_flag(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         error_count++;
         $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
         $display("Done: errors found");
         $fatal(1, "flag check failed");
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      arst_n  <= 1'b0;
      run     <= 1'b0;
      prog_we <= 1'b0;
      repeat (16) @(posedge clk);
      arst_n  <= 1'b1;
   endtask

   // Byte writes, image padded with NOPs past its end
   task automatic load_program();
      word_t w;
      for (int byte_addr = 0; byte_addr < (image_len + 4) * 4; byte_addr++) begin
         w = (byte_addr / 4 < image_len) ? image[byte_addr / 4] : NOP_INSTR;
         @(posedge clk);
         prog_addr <= byte_addr;
         prog_data <= w[8 * (byte_addr % 4) +: 8];
         prog_we   <= 1'b1;
      end
      @(posedge clk);
      prog_we <= 1'b0;
   endtask

   task automatic wait_halted();
      int cycles;
      cycles = 0;
      while (halted !== 1'b1) begin
         if (cycles >= HALT_TIMEOUT) begin
            $display("timeout: halted never rose within %0d cycles", HALT_TIMEOUT);
            $display("Done: errors found");
            $fatal(1, "halt wait timed out");
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic check_regs(input reg_file_t expected);
      word_t value;
      for (int i = 0; i < 32; i++) begin
         @(posedge clk);
         debug_addr <= reg_idx_t'(i);
         @(negedge clk);                        // Combinational read settled
         value = debug_data;
         check_word($sformatf("x%0d", i), value, expected[i]);
      end
   endtask

   task automatic run_program();
      reg_file_t expected;
      expected = iss_run();
      apply_reset();
      load_program();
      @(negedge clk);
      check_flag("halted", halted, 1'b0);       // Cleared by reset
      @(posedge clk);
      run <= 1'b1;
      wait_halted();
      check_regs(expected);
      check_flag("halted", halted, 1'b1);       // Still set after the reads
   endtask

   function automatic void build_forwarding();
      image_len = 0;
      emit(addi(1, 0, 5));
      emit(addi(2, 1, 7));                      // EX/MEM path
      emit(r_type(0, 2, 1, 0, 3));              // Both paths
      emit(r_type(32, 1, 3, 0, 4));             // SUB
      emit(r_type(0, 2, 4, 4, 5));
      emit(r_type(0, 3, 5, 6, 6));
      emit(r_type(0, 4, 6, 7, 7));
      emit(r_type(0, 3, 4, 2, 8));              // SLT
      emit(addi(9, 0, -3));
      emit(r_type(0, 1, 9, 2, 10));             // Signed compare of negative
      emit(i_type(12'h5a5, 10, 4, 11, OPC_OPIMM));
      emit(i_type(-16, 11, 6, 12, OPC_OPIMM));
      emit(i_type(12'h0f0, 12, 7, 13, OPC_OPIMM));
      emit(u_type(20'habcde, 14));
      emit(addi(14, 14, 12'h123));
      emit(EBREAK_INSTR);
   endfunction

   function automatic void build_memory();
      image_len = 0;
      emit(addi(1, 0, 12'h055));
      emit(u_type(20'h12345, 2));
      emit(addi(2, 2, 12'h678));
      emit(s_type(8, 2, 0));
      emit(s_type(12, 1, 0));
      emit(i_type(8, 0, 2, 3, OPC_LOAD));
      emit(r_type(0, 1, 3, 0, 4));              // Load-use stall
      emit(i_type(12, 0, 2, 5, OPC_LOAD));
      emit(s_type(16, 5, 0));                   // Stall on store data
      emit(i_type(16, 0, 2, 6, OPC_LOAD));
      emit(r_type(0, 6, 6, 0, 7));
      emit(EBREAK_INSTR);
   endfunction

   function automatic void build_branches();
      image_len = 0;
      emit(addi(1, 0, 3));
      emit(addi(2, 0, 3));
      emit(b_type(12, 2, 1, 0));                // BEQ taken
      emit(addi(20, 0, 1));                     // Wrong-path marker
      emit(addi(21, 0, 1));
      emit(b_type(12, 2, 1, 1));                // BNE not taken
      emit(addi(3, 0, 9));
      emit(j_type(12, 5));                      // JAL, link 32
      emit(addi(22, 0, 1));
      emit(addi(23, 0, 1));
      emit(b_type(12, 1, 3, 1));                // BNE taken
      emit(addi(24, 0, 1));
      emit(addi(25, 0, 1));
      emit(b_type(8, 1, 3, 0));                 // BEQ not taken
      emit(r_type(0, 3, 5, 0, 6));
      emit(EBREAK_INSTR);
   endfunction

   function automatic void build_halt();
      image_len = 0;
      emit(addi(1, 0, 1));
      emit(addi(2, 0, 2));
      emit(EBREAK_INSTR);
      emit(addi(3, 0, 3));                      // Must never retire
      emit(r_type(0, 2, 1, 0, 4));
      emit(addi(1, 0, 99));
   endfunction

   function automatic void build_random();
      int kind;
      int rd;
      int rs1;
      int rs2;
      int op;
      int skip;
      image_len = 0;
      for (int k = 0; k < WINDOW_WORDS; k++) begin
         emit(s_type(k * 4, 0, 0));             // Data window starts known
      end
      for (int i = 0; i < BODY_LEN; i++) begin
         kind = rand_below(10);
         rd   = rand_below(32);
         rs1  = rand_below(32);
         rs2  = rand_below(32);
         op   = rand_below(6);
         skip = rand_below(3) + 1;
         if (skip > BODY_LEN - 1 - i) begin
            skip = BODY_LEN - 1 - i;            // Target stays at or before EBREAK
         end
         case (kind)
            0, 1, 2: begin
               case (op)
                  0:       emit(r_type(0, rs2, rs1, 0, rd));
                  1:       emit(r_type(32, rs2, rs1, 0, rd));
                  2:       emit(r_type(0, rs2, rs1, 7, rd));
                  3:       emit(r_type(0, rs2, rs1, 6, rd));
                  4:       emit(r_type(0, rs2, rs1, 4, rd));
                  default: emit(r_type(0, rs2, rs1, 2, rd));
               endcase
            end
            3, 4: begin
               case (op % 4)
                  0:       emit(i_type(rand_below(4096), rs1, 0, rd, OPC_OPIMM));
                  1:       emit(i_type(rand_below(4096), rs1, 7, rd, OPC_OPIMM));
                  2:       emit(i_type(rand_below(4096), rs1, 6, rd, OPC_OPIMM));
                  default: emit(i_type(rand_below(4096), rs1, 4, rd, OPC_OPIMM));
               endcase
            end
            5:       emit(u_type(rand_below(1 << 20), rd));
            6:       emit(i_type(rand_below(WINDOW_WORDS) * 4, 0, 2, rd, OPC_LOAD));
            7:       emit(s_type(rand_below(WINDOW_WORDS) * 4, rs2, 0));
            8:       emit(b_type((skip + 1) * 4, rs2, rs1, op % 2));
            default: emit(j_type((skip + 1) * 4, rd));
         endcase
      end
      emit(EBREAK_INSTR);
   endfunction

   initial begin
      reg_file_t zeros;
      zeros = '0;
      apply_reset();
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_flag("halted", halted, 1'b0);       // Idle with run low
      check_regs(zeros);
      build_forwarding();
      run_program();
      build_memory();
      run_program();
      build_branches();
      run_program();
      build_halt();
      run_program();
      for (int p = 0; p < RANDOM_PROGRAMS; p++) begin
         build_random();
         run_program();
      end
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== verification/cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties import cpu_pkg::*; (
   input logic     clk,
   input logic     arst_n,
   input logic     halted,
   input reg_idx_t debug_addr,
   input word_t    debug_data,
   input logic     if_id_stall,
   input logic     if_id_flush,
   input logic     wb_en,
   input reg_idx_t wb_rd
);

   int failures = 0;                    // Failed assertion count

   halted_sticky: assert property (@(posedge clk) disable iff (!arst_n)
                                   halted |=> halted)
      else begin
         $error("halted fell while reset was inactive");
         failures++;
      end

   debug_x0_zero: assert property (@(posedge clk)
                                   (debug_addr == '0) |-> (debug_data == '0))
      else begin
         $error("debug read of x0 returned a nonzero value");
         failures++;
      end

   // ID/EX has no hold path, so IF/ID is the register that can see both controls
   stall_flush_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
                                           !(if_id_stall && if_id_flush))
      else begin
         $error("pipeline register stalled and flushed in the same cycle");
         failures++;
      end

   no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
                                 wb_en |-> (wb_rd != '0))
      else begin
         $error("register file write with x0 as destination");
         failures++;
      end

endmodule

bind cpu cpu_properties u_cpu_properties (
   .clk         (clk),
   .arst_n      (arst_n),
   .halted      (halted),
   .debug_addr  (debug_addr),
   .debug_data  (debug_data),
   .if_id_stall (if_id_stall),
   .if_id_flush (if_id_flush),
   .wb_en       (wb_en),
   .wb_rd       (mem_wb_reg.rd)
);

// ==== logic/cpu.sv ====
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  word_t      prog_addr,
   input  logic [7:0] prog_data,
   input  logic       prog_we,
   input  logic       run,
   input  reg_idx_t   debug_addr,
   output word_t      debug_data,
   output logic       halted
);

   if_id_t  if_id_reg;
   id_ex_t  id_ex_reg;
   ex_mem_t ex_mem_reg;
   mem_wb_t mem_wb_reg;

   id_ex_t  id_ex_next;                 // Stage results
   ex_mem_t ex_mem_next;
   mem_wb_t mem_wb_next;

   word_t    fetch_pc;
   word_t    fetch_instr;
   logic     halt_seen;
   logic     load_use;
   fwd_sel_e fwd_sel_rs1;
   fwd_sel_e fwd_sel_rs2;
   logic     branch_taken;
   word_t    branch_target;

   logic  wb_en;
   word_t wb_data;

   logic pc_stall;
   logic pc_redirect;
   logic if_id_stall;
   logic if_id_flush;
   logic id_ex_flush;
   logic fetch_hold;

   // EBREAK anywhere in flight keeps fetch frozen until halted takes over
   assign fetch_hold = halt_seen | id_ex_reg.ctrl.is_halt | ex_mem_reg.ctrl.is_halt |
                       mem_wb_reg.ctrl.is_halt | halted | !run;

   always_comb begin
      pc_stall    = 1'b0;
      pc_redirect = 1'b0;
      if_id_stall = 1'b0;
      if_id_flush = 1'b0;
      id_ex_flush = 1'b0;
      if (load_use) begin               // Hold decode, bubble into execute
         pc_stall    = 1'b1;
         if_id_stall = 1'b1;
         id_ex_flush = 1'b1;
      end else if (branch_taken) begin  // Drop the two wrong-path slots
         pc_redirect = 1'b1;
         if_id_flush = 1'b1;
         id_ex_flush = 1'b1;
      end else if (fetch_hold) begin
         pc_stall    = 1'b1;
         if_id_flush = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         if_id_reg.pc          <= '0;
         if_id_reg.instruction <= NOP_INSTR;
      end else if (if_id_flush) begin
         if_id_reg.pc          <= '0;
         if_id_reg.instruction <= NOP_INSTR;
      end else if (!if_id_stall) begin
         if_id_reg.pc          <= fetch_pc;
         if_id_reg.instruction <= fetch_instr;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex_reg <= '0;
      end else if (id_ex_flush) begin
         id_ex_reg <= '0;               // Bubble, all control low
      end else begin
         id_ex_reg <= id_ex_next;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem_reg <= '0;
         mem_wb_reg <= '0;
      end else begin
         ex_mem_reg <= ex_mem_next;
         mem_wb_reg <= mem_wb_next;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halted <= 1'b0;
      end else if (mem_wb_reg.ctrl.is_halt) begin
         halted <= 1'b1;                // Sticky until reset
      end
   end

   assign wb_en   = mem_wb_reg.ctrl.reg_write && (mem_wb_reg.rd != '0);
   assign wb_data = mem_wb_reg.ctrl.mem_read ? mem_wb_reg.load_data : mem_wb_reg.alu_data;

   program_memory u_program_memory (
      .clk         (clk),
      .prog_addr   (prog_addr),
      .prog_data   (prog_data),
      .prog_we     (prog_we),
      .fetch_addr  (fetch_pc),
      .instruction (fetch_instr)
   );

   fetch_stage u_fetch_stage (
      .clk           (clk),
      .arst_n        (arst_n),
      .pc_stall      (pc_stall),
      .branch_taken  (pc_redirect),
      .branch_target (branch_target),
      .pc            (fetch_pc)
   );

   decode_stage u_decode_stage (
      .clk        (clk),
      .arst_n     (arst_n),
      .if_id      (if_id_reg),
      .wb_en      (wb_en),
      .wb_rd      (mem_wb_reg.rd),
      .wb_data    (wb_data),
      .debug_addr (debug_addr),
      .debug_data (debug_data),
      .id_ex_next (id_ex_next),
      .halt_seen  (halt_seen)
   );

   hazard_unit u_hazard_unit (
      .if_id       (if_id_reg),
      .id_ex       (id_ex_reg),
      .ex_mem      (ex_mem_reg),
      .mem_wb      (mem_wb_reg),
      .load_use    (load_use),
      .fwd_sel_rs1 (fwd_sel_rs1),
      .fwd_sel_rs2 (fwd_sel_rs2)
   );

   execute_stage u_execute_stage (
      .id_ex         (id_ex_reg),
      .fwd_sel_rs1   (fwd_sel_rs1),
      .fwd_sel_rs2   (fwd_sel_rs2),
      .fwd_ex_mem    (ex_mem_reg.alu_data),
      .fwd_mem_wb    (wb_data),
      .ex_mem_next   (ex_mem_next),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

   mem_stage u_mem_stage (
      .clk         (clk),
      .ex_mem      (ex_mem_reg),
      .mem_wb_next (mem_wb_next)
   );

endmodule

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import cpu_pkg::*; (
   input  logic    clk,
   input  ex_mem_t ex_mem,
   output mem_wb_t mem_wb_next
);

   word_t dmem [DMEM_WORDS];

   logic [DMEM_AW-1:0] word_idx;

   assign word_idx = ex_mem.alu_data[DMEM_AW+1:2];   // Word index, wraps

   always_ff @(posedge clk) begin
      if (ex_mem.ctrl.mem_write) begin
         dmem[word_idx] <= ex_mem.store_data;         // SW at the edge
      end
   end

   always_comb begin
      mem_wb_next.alu_data  = ex_mem.alu_data;
      mem_wb_next.load_data = dmem[word_idx];         // LW combinational
      mem_wb_next.rd        = ex_mem.rd;
      mem_wb_next.ctrl      = ex_mem.ctrl;
   end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
   input  id_ex_t   id_ex,
   input  fwd_sel_e fwd_sel_rs1,
   input  fwd_sel_e fwd_sel_rs2,
   input  word_t    fwd_ex_mem,
   input  word_t    fwd_mem_wb,
   output ex_mem_t  ex_mem_next,
   output logic     branch_taken,
   output word_t    branch_target
);

   word_t op_a;
   word_t op_b_reg;                     // Forwarded rs2, also the store data
   word_t alu_b;
   word_t alu_result;
   word_t pc_plus4;
   logic  operands_eq;

   function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t em_val,
                                     word_t mw_val);
      case (sel)
         FWD_EX_MEM: return em_val;
         FWD_MEM_WB: return mw_val;
         default:    return reg_val;
      endcase
   endfunction

   assign op_a     = fwd_mux(fwd_sel_rs1, id_ex.data1, fwd_ex_mem, fwd_mem_wb);
   assign op_b_reg = fwd_mux(fwd_sel_rs2, id_ex.data2, fwd_ex_mem, fwd_mem_wb);
   assign alu_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b_reg;
   assign pc_plus4 = id_ex.pc + 32'd4;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         ALU_SUB:    alu_result = op_a - alu_b;
         ALU_AND:    alu_result = op_a & alu_b;
         ALU_OR:     alu_result = op_a | alu_b;
         ALU_XOR:    alu_result = op_a ^ alu_b;
         ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(alu_b)};
         ALU_PASS_B: alu_result = alu_b;
         default:    alu_result = op_a + alu_b;     // Also LW/SW address
      endcase
   end

   // Branch compare on the register operands, not the ALU B input
   assign operands_eq   = (op_a == op_b_reg);
   assign branch_taken  = id_ex.ctrl.is_jump ||
                          (id_ex.ctrl.is_branch && (operands_eq ^ id_ex.ctrl.branch_ne));
   assign branch_target = id_ex.pc + id_ex.imm;

   always_comb begin
      ex_mem_next.alu_data   = id_ex.ctrl.is_jump ? pc_plus4 : alu_result;   // JAL link
      ex_mem_next.store_data = op_b_reg;
      ex_mem_next.rd         = id_ex.rd;
      ex_mem_next.ctrl       = id_ex.ctrl;
   end

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
   input  if_id_t   if_id,
   input  id_ex_t   id_ex,
   input  ex_mem_t  ex_mem,
   input  mem_wb_t  mem_wb,
   output logic     load_use,
   output fwd_sel_e fwd_sel_rs1,
   output fwd_sel_e fwd_sel_rs2
);

   logic [6:0] opcode;
   reg_idx_t   dec_rs1;
   reg_idx_t   dec_rs2;
   logic       uses_rs1;
   logic       uses_rs2;

   assign opcode   = if_id.instruction[6:0];
   assign dec_rs1  = if_id.instruction[19:15];
   assign dec_rs2  = if_id.instruction[24:20];
   assign uses_rs1 = opcode inside {OPC_OP, OPC_OPIMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
   assign uses_rs2 = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};   // No false stalls

   assign load_use = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                     ((uses_rs1 && dec_rs1 == id_ex.rd) || (uses_rs2 && dec_rs2 == id_ex.rd));

   // Youngest producer wins
   function automatic fwd_sel_e pick(reg_idx_t rs, ex_mem_t em, mem_wb_t mw);
      if (rs != '0 && em.ctrl.reg_write && em.rd == rs) begin
         return FWD_EX_MEM;
      end else if (rs != '0 && mw.ctrl.reg_write && mw.rd == rs) begin
         return FWD_MEM_WB;
      end
      return FWD_NONE;
   endfunction

   assign fwd_sel_rs1 = pick(id_ex.ctrl.rs1, ex_mem, mem_wb);
   assign fwd_sel_rs2 = pick(id_ex.ctrl.rs2, ex_mem, mem_wb);

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  if_id_t   if_id,
   input  logic     wb_en,
   input  reg_idx_t wb_rd,
   input  word_t    wb_data,
   input  reg_idx_t debug_addr,
   output word_t    debug_data,
   output id_ex_t   id_ex_next,
   output logic     halt_seen
);

   word_t regs [1:31];                  // x0 is not stored

   word_t      instr;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_idx_t   rs1_f;
   reg_idx_t   rs2_f;
   alu_op_e    arith_op;
   ctrl_t      ctrl;
   word_t      imm;

   assign instr  = if_id.instruction;
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1_f  = instr[19:15];
   assign rs2_f  = instr[24:20];

   assign halt_seen = (opcode == OPC_SYSTEM);   // EBREAK

   // Same funct3 map for register and immediate forms
   always_comb begin
      case (funct3)
         3'b111:  arith_op = ALU_AND;
         3'b110:  arith_op = ALU_OR;
         3'b100:  arith_op = ALU_XOR;
         3'b010:  arith_op = ALU_SLT;
         default: arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      endcase
   end

   always_comb begin
      ctrl = '0;
      imm  = '0;
      case (opcode)
         OPC_OP: begin
            ctrl.alu_op    = arith_op;
            ctrl.reg_write = 1'b1;
            ctrl.rs1       = rs1_f;
            ctrl.rs2       = rs2_f;
         end
         OPC_OPIMM: begin
            ctrl.alu_op      = arith_op;
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.rs1         = rs1_f;
            imm              = {{20{instr[31]}}, instr[31:20]};   // I type
         end
         OPC_LUI: begin
            ctrl.alu_op      = ALU_PASS_B;
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            imm              = {instr[31:12], 12'b0};              // U type
         end
         OPC_LOAD: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.rs1         = rs1_f;
            imm              = {{20{instr[31]}}, instr[31:20]};
         end
         OPC_STORE: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_write   = 1'b1;
            ctrl.rs1         = rs1_f;
            ctrl.rs2         = rs2_f;
            imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // S type
         end
         OPC_BRANCH: begin
            ctrl.is_branch = 1'b1;
            ctrl.branch_ne = funct3[0];    // 001 is BNE
            ctrl.rs1       = rs1_f;
            ctrl.rs2       = rs2_f;
            imm            = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};                  // B type
         end
         OPC_JAL: begin
            ctrl.is_jump   = 1'b1;
            ctrl.reg_write = 1'b1;          // Link written from pc+4
            imm            = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};                 // J type
         end
         OPC_SYSTEM: begin
            ctrl.is_halt = 1'b1;
         end
         default: ctrl = '0;                // Unknown opcode acts as a bubble
      endcase
   end

   function automatic word_t read_port(reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end else if (wb_en && idx == wb_rd) begin
         return wb_data;                    // Write-through
      end
      return regs[idx];
   endfunction

   always_comb begin
      id_ex_next.pc    = if_id.pc;
      id_ex_next.data1 = read_port(rs1_f);
      id_ex_next.data2 = read_port(rs2_f);
      id_ex_next.imm   = imm;
      id_ex_next.rd    = instr[11:7];
      id_ex_next.ctrl  = ctrl;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en && wb_rd != '0) begin
         regs[wb_rd] <= wb_data;            // Writes to x0 dropped
      end
   end

   always_comb begin
      debug_data = (debug_addr == '0) ? '0 : regs[debug_addr];
   end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
   input  logic  clk,
   input  logic  arst_n,
   input  logic  pc_stall,
   input  logic  branch_taken,
   input  word_t branch_target,
   output word_t pc
);

   word_t pc_plus4;

   assign pc_plus4 = pc + 32'd4;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc <= '0;                      // Fetch starts at address 0
      end else if (branch_taken) begin
         pc <= branch_target;           // Redirect wins over stall
      end else if (!pc_stall) begin
         pc <= pc_plus4;
      end
   end

endmodule

// ==== logic/program_memory.sv ====
`timescale 1ns/1ps

module program_memory import cpu_pkg::*; (
   input  logic       clk,
   input  word_t      prog_addr,
   input  logic [7:0] prog_data,
   input  logic       prog_we,
   input  word_t      fetch_addr,
   output word_t      instruction
);

   logic [7:0] mem [IMEM_BYTES];

   logic [IMEM_AW-1:0] wr_idx;
   logic [IMEM_AW-1:0] rd_base;

   assign wr_idx  = prog_addr[IMEM_AW-1:0];          // Wraps modulo the size
   assign rd_base = {fetch_addr[IMEM_AW-1:2], 2'b00}; // Word aligned

   always_ff @(posedge clk) begin
      if (prog_we) begin
         mem[wr_idx] <= prog_data;                     // One byte per edge
      end
   end

   // Little endian, lowest address in bits 7:0
   assign instruction = {mem[rd_base + 2'd3],
                         mem[rd_base + 2'd2],
                         mem[rd_base + 2'd1],
                         mem[rd_base]};

endmodule

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

   typedef logic [31:0] word_t;                  // Data, address or instruction word
   typedef logic [4:0]  reg_idx_t;               // Register index

   localparam int IMEM_BYTES = 1024;             // Program memory size in bytes
   localparam int DMEM_WORDS = 256;              // Data memory size in words
   localparam int IMEM_AW    = $clog2(IMEM_BYTES);
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);

   localparam word_t NOP_INSTR = 32'h0000_0013;  // ADDI x0,x0,0

   // RV32I major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B                                 // LUI passes the immediate
   } alu_op_e;

   typedef enum logic [1:0] {
      FWD_NONE,                                  // Operand from ID/EX
      FWD_EX_MEM,
      FWD_MEM_WB
   } fwd_sel_e;

   typedef struct packed {
      alu_op_e  alu_op;
      logic     alu_src_imm;                     // B operand is the immediate
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     is_branch;
      logic     branch_ne;                       // BNE when set, else BEQ
      logic     is_jump;
      logic     is_halt;
      reg_idx_t rs1;                             // Zero when not read
      reg_idx_t rs2;
   } ctrl_t;

   typedef struct packed {
      word_t pc;
      word_t instruction;
   } if_id_t;

   typedef struct packed {
      word_t    pc;
      word_t    data1;
      word_t    data2;
      word_t    imm;
      reg_idx_t rd;
      ctrl_t    ctrl;
   } id_ex_t;

   typedef struct packed {
      word_t    alu_data;                        // Memory address for LW/SW
      word_t    store_data;
      reg_idx_t rd;
      ctrl_t    ctrl;
   } ex_mem_t;

   typedef struct packed {
      word_t    alu_data;
      word_t    load_data;
      reg_idx_t rd;
      ctrl_t    ctrl;
   } mem_wb_t;

endpackage
